// ==== source/video_timing_pkg.sv ====
package video_timing_pkg;

    // Coordinate widths, sized for a 1280x720 class raster
    localparam int X_BITS = 11;
    localparam int Y_BITS = 10;

    typedef logic [X_BITS-1:0] x_coord_t;
    typedef logic [Y_BITS-1:0] y_coord_t;

    // One raster position as seen by the display side
    typedef struct packed {
        logic     hs;
        logic     vs;
        logic     de;
        logic     line_start; // First de cycle of a line
        x_coord_t x;          // Zero outside the active area
        y_coord_t y;
    } raster_t;

endpackage : video_timing_pkg

// ==== source/pixel_pkg.sv ====
package pixel_pkg;

    import video_timing_pkg::*;

    // Camera side pixel, red sits in the low bits
    typedef struct packed {
        logic [4:0] b;
        logic [5:0] g;
        logic [4:0] r;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Display side packet, 49 bits
    typedef struct packed {
        logic     hs;
        logic     vs;
        logic     de;
        logic     line_start;
        rgb888_t  color;
        x_coord_t x;
        y_coord_t y;
    } disp_packet_t;

    // Widen each channel by padding zeros below the MSBs
    function automatic rgb888_t expand_565(rgb565_t p);
        rgb888_t c;
        c.r = {p.r, 3'b000};
        c.g = {p.g, 2'b00};
        c.b = {p.b, 3'b000};
        return c;
    endfunction

endpackage : pixel_pkg

// ==== source/display_ctrl.sv ====
`timescale 1ns/1ps

module display_ctrl (
    input  logic clk,
    input  logic svg_rstn,
    input  logic i_vsync,
    output logic o_run
);

    logic vsync_d;
    logic vsync_rise;

    // Previous vsync sample for the edge detector
    always_ff @(posedge clk) begin
        vsync_d <= i_vsync;
    end

    assign vsync_rise = i_vsync & ~vsync_d;

    // Run latch, set once by the first rising edge
    always_ff @(posedge clk) begin
        if (!svg_rstn) begin
            o_run <= 1'b0;
        end else if (vsync_rise) begin
            o_run <= 1'b1; // Later edges change nothing
        end
    end

endmodule : display_ctrl

// ==== source/sync_gen.sv ====
`timescale 1ns/1ps

module sync_gen #(
    parameter int H_SYNC = 12,
    parameter int H_BP   = 300,
    parameter int H_ACT  = 1280,
    parameter int H_FP   = 300,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 9,
    parameter int V_ACT  = 720,
    parameter int V_FP   = 9
) (
    input  logic                      clk,
    input  logic                      svg_rstn,
    input  logic                      i_run,
    output video_timing_pkg::raster_t o_raster
);

    import video_timing_pkg::*;

    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;

    // Compare points at counter width
    localparam x_coord_t H_LAST     = x_coord_t'(H_TOTAL - 1);
    localparam x_coord_t H_SYNC_END = x_coord_t'(H_SYNC);
    localparam x_coord_t H_ACT_BEG  = x_coord_t'(H_SYNC + H_BP);
    localparam x_coord_t H_ACT_END  = x_coord_t'(H_SYNC + H_BP + H_ACT);

    localparam y_coord_t V_LAST     = y_coord_t'(V_TOTAL - 1);
    localparam y_coord_t V_SYNC_END = y_coord_t'(V_SYNC);
    localparam y_coord_t V_ACT_BEG  = y_coord_t'(V_SYNC + V_BP);
    localparam y_coord_t V_ACT_END  = y_coord_t'(V_SYNC + V_BP + V_ACT);

    x_coord_t h_cnt;
    y_coord_t v_cnt;
    logic     h_act;
    logic     v_act;
    logic     in_act;

    always_ff @(posedge clk) begin
        if (!svg_rstn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (i_run) begin
            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                if (v_cnt == V_LAST) begin
                    v_cnt <= '0; // End of frame
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    assign h_act  = (h_cnt >= H_ACT_BEG) && (h_cnt < H_ACT_END);
    assign v_act  = (v_cnt >= V_ACT_BEG) && (v_cnt < V_ACT_END);
    assign in_act = h_act && v_act;

    // Raster stays all zeros until the generator is started
    always_comb begin
        o_raster = '0;
        if (i_run) begin
            o_raster.hs         = h_cnt < H_SYNC_END;
            o_raster.vs         = v_cnt < V_SYNC_END;
            o_raster.de         = in_act;
            o_raster.line_start = in_act && (h_cnt == H_ACT_BEG);
            if (in_act) begin
                o_raster.x = h_cnt - H_ACT_BEG;
                o_raster.y = v_cnt - V_ACT_BEG;
            end
        end
    end

endmodule : sync_gen

// ==== source/pixel_delay.sv ====
`timescale 1ns/1ps

module pixel_delay #(
    parameter int DEPTH = 25
) (
    input  logic               clk,
    input  pixel_pkg::rgb565_t i_pix,
    output pixel_pkg::rgb565_t o_pix
);

    import pixel_pkg::*;

    rgb565_t pipe [DEPTH];

    // Plain shift chain, one stage per clock
    always_ff @(posedge clk) begin
        pipe[0] <= i_pix;
        for (int i = 1; i < DEPTH; i++) begin
            pipe[i] <= pipe[i-1];
        end
    end

    assign o_pix = pipe[DEPTH-1];

endmodule : pixel_delay

// ==== source/disp_pack.sv ====
`timescale 1ns/1ps

module disp_pack (
    input  logic                        clk,
    input  logic                        svg_rstn,
    input  video_timing_pkg::raster_t   i_raster,
    input  pixel_pkg::rgb565_t          i_pix,
    output pixel_pkg::disp_packet_t     o_pack
);

    import pixel_pkg::*;

    rgb888_t color;

    // Colour only shows inside the active area
    assign color = i_raster.de ? expand_565(i_pix) : '0;

    always_ff @(posedge clk) begin
        if (!svg_rstn) begin
            o_pack <= '0;
        end else begin
            o_pack.hs         <= i_raster.hs;
            o_pack.vs         <= i_raster.vs;
            o_pack.de         <= i_raster.de;
            o_pack.line_start <= i_raster.line_start;
            o_pack.color      <= color;
            o_pack.x          <= i_raster.x;
            o_pack.y          <= i_raster.y;
        end
    end

endmodule : disp_pack

// ==== source/hdmi_display.sv ====
`timescale 1ns/1ps

module hdmi_display #(
    parameter int H_SYNC     = 12,
    parameter int H_BP       = 300,
    parameter int H_ACT      = 1280,
    parameter int H_FP       = 300,
    parameter int V_SYNC     = 2,
    parameter int V_BP       = 9,
    parameter int V_ACT      = 720,
    parameter int V_FP       = 9,
    parameter int DATA_DELAY = 25  // Pixel pipe depth before the packer
) (
    input  logic                    clk,
    input  logic                    svg_rstn,
    input  logic                    i_vsync,
    input  logic                    i_href,   // Not used, kept on the port list
    input  pixel_pkg::rgb565_t      i_data,
    output pixel_pkg::disp_packet_t o_pack
);

    import video_timing_pkg::*;
    import pixel_pkg::*;

    logic    run;
    raster_t raster;
    rgb565_t pix_dly;

    // Frame start follows the source vsync
    display_ctrl u_display_ctrl (
        .clk      (clk),
        .svg_rstn (svg_rstn),
        .i_vsync  (i_vsync),
        .o_run    (run)
    );

    sync_gen #(
        .H_SYNC (H_SYNC),
        .H_BP   (H_BP),
        .H_ACT  (H_ACT),
        .H_FP   (H_FP),
        .V_SYNC (V_SYNC),
        .V_BP   (V_BP),
        .V_ACT  (V_ACT),
        .V_FP   (V_FP)
    ) u_sync_gen (
        .clk      (clk),
        .svg_rstn (svg_rstn),
        .i_run    (run),
        .o_raster (raster)
    );

    pixel_delay #(
        .DEPTH (DATA_DELAY)
    ) u_pixel_delay (
        .clk   (clk),
        .i_pix (i_data),
        .o_pix (pix_dly)
    );

    disp_pack u_disp_pack (
        .clk      (clk),
        .svg_rstn (svg_rstn),
        .i_raster (raster),
        .i_pix    (pix_dly),
        .o_pack   (o_pack)
    );

endmodule : hdmi_display

// ==== bench/hdmi_display_sva.sv ====
`timescale 1ns/1ps

module hdmi_display_sva #(
    parameter int H_ACT = 1280,
    parameter int V_ACT = 720
) (
    input logic                      clk,
    input logic                      svg_rstn,
    input logic                      i_run,
    input video_timing_pkg::raster_t i_raster,
    input pixel_pkg::disp_packet_t   i_pack
);

    import video_timing_pkg::*;

    localparam x_coord_t X_LIM = x_coord_t'(H_ACT);
    localparam y_coord_t Y_LIM = y_coord_t'(V_ACT);

    // Active video never overlaps a sync pulse
    raster_de_no_sync: assert property (@(posedge clk) disable iff (!svg_rstn)
        i_raster.de |-> !i_raster.hs && !i_raster.vs)
        else $error("raster de overlaps a sync pulse");

    pack_de_no_sync: assert property (@(posedge clk) disable iff (!svg_rstn)
        i_pack.de |-> !i_pack.hs && !i_pack.vs)
        else $error("packet de overlaps a sync pulse");

    pack_line_start: assert property (@(posedge clk) disable iff (!svg_rstn)
        i_pack.line_start |-> i_pack.de && (i_pack.x == '0))
        else $error("line start outside the first active pixel");

    pack_x_range: assert property (@(posedge clk) disable iff (!svg_rstn)
        i_pack.x < X_LIM)
        else $error("packet x beyond the active width");

    pack_y_range: assert property (@(posedge clk) disable iff (!svg_rstn)
        i_pack.y < Y_LIM)
        else $error("packet y beyond the active height");

    // Generator idle means an empty packet
    pack_idle_zero: assert property (@(posedge clk) disable iff (!svg_rstn)
        !i_run |-> i_pack == '0)
        else $error("packet not empty while the generator is idle");

endmodule : hdmi_display_sva

bind hdmi_display hdmi_display_sva #(
    .H_ACT (H_ACT),
    .V_ACT (V_ACT)
) u_sva (
    .clk      (clk),
    .svg_rstn (svg_rstn),
    .i_run    (run),
    .i_raster (raster),
    .i_pack   (o_pack)
);

// ==== bench/hdmi_display_tb.sv ====
`timescale 1ns/1ps

module hdmi_display_tb;

    import pixel_pkg::*;

    localparam int H_SYNC     = 2;
    localparam int H_BP       = 3;
    localparam int H_ACT      = 8;
    localparam int H_FP       = 2;
    localparam int V_SYNC     = 1;
    localparam int V_BP       = 1;
    localparam int V_ACT      = 4;
    localparam int V_FP       = 1;
    localparam int DATA_DELAY = 5;

    localparam int H_TOTAL = H_SYNC + H_BP + H_ACT + H_FP;
    localparam int V_TOTAL = V_SYNC + V_BP + V_ACT + V_FP;
    localparam int FRAME   = H_TOTAL * V_TOTAL;
    localparam int LIMIT   = 3 * FRAME; // Cycles before a wait gives up

    logic         clk = 1'b0;
    logic         svg_rstn;
    logic         i_vsync;
    logic         i_href;
    rgb565_t      i_data;
    disp_packet_t o_pack;

    integer seed = 68;
    int     mismatch_errors = 0;
    int     timeout_errors  = 0;
    int     model_edges = 0;
    int     de_count = 0;
    int     line_count = 0;

    // Reference model state
    logic        m_vs_prev = 1'b0;
    logic        m_run = 1'b0;
    int          m_h = 0;
    int          m_v = 0;
    logic [15:0] hist[$];
    logic        e_hs, e_vs, e_de, e_ls;
    logic [23:0] e_color;
    int          e_x, e_y;

    hdmi_display #(
        .H_SYNC     (H_SYNC),
        .H_BP       (H_BP),
        .H_ACT      (H_ACT),
        .H_FP       (H_FP),
        .V_SYNC     (V_SYNC),
        .V_BP       (V_BP),
        .V_ACT      (V_ACT),
        .V_FP       (V_FP),
        .DATA_DELAY (DATA_DELAY)
    ) DUT (
        .clk      (clk),
        .svg_rstn (svg_rstn),
        .i_vsync  (i_vsync),
        .i_href   (i_href),
        .i_data   (i_data),
        .o_pack   (o_pack)
    );

    always #4 clk = ~clk;

    // RGB565 to RGB888 by zero padding below each channel
    function automatic logic [23:0] widen_565(logic [15:0] s);
        return {s[4:0], 3'b000, s[10:5], 2'b00, s[15:11], 3'b000};
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, actual,
                     expected);
            mismatch_errors++;
        end
    endtask

    task automatic close_run();
        $display("Error count: %0d mismatches, %0d timeouts", mismatch_errors,
                 timeout_errors);
        if (mismatch_errors == 0 && timeout_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // Model advances on the same edge the DUT samples its inputs
    always @(posedge clk) begin
        logic [15:0] din;
        logic [15:0] old;
        logic        h_in;
        logic        v_in;
        din = i_data;
        hist.push_back(din);
        if (hist.size() > DATA_DELAY + 1) begin
            void'(hist.pop_front());
        end
        old  = (hist.size() == DATA_DELAY + 1) ? hist[0] : 16'h0000;
        h_in = (m_h >= H_SYNC + H_BP) && (m_h < H_SYNC + H_BP + H_ACT);
        v_in = (m_v >= V_SYNC + V_BP) && (m_v < V_SYNC + V_BP + V_ACT);

        e_hs    = svg_rstn && m_run && (m_h < H_SYNC);
        e_vs    = svg_rstn && m_run && (m_v < V_SYNC);
        e_de    = svg_rstn && m_run && h_in && v_in;
        e_ls    = e_de && (m_h == H_SYNC + H_BP);
        e_color = e_de ? widen_565(old) : 24'h000000;
        e_x     = e_de ? m_h - H_SYNC - H_BP : 0;
        e_y     = e_de ? m_v - V_SYNC - V_BP : 0;

        if (!svg_rstn) begin
            m_run = 1'b0;
            m_h   = 0;
            m_v   = 0;
        end else begin
            if (m_run) begin
                if (m_h == H_TOTAL - 1) begin
                    m_h = 0;
                    m_v = (m_v == V_TOTAL - 1) ? 0 : m_v + 1;
                end else begin
                    m_h = m_h + 1;
                end
            end
            if (i_vsync && !m_vs_prev) begin
                m_run = 1'b1; // Only the first rise matters
            end
        end
        m_vs_prev = i_vsync;
        model_edges++;
    end

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (model_edges > 0) begin
            check_value("hs", 32'(o_pack.hs), 32'(e_hs));
            check_value("vs", 32'(o_pack.vs), 32'(e_vs));
            check_value("de", 32'(o_pack.de), 32'(e_de));
            check_value("line_start", 32'(o_pack.line_start), 32'(e_ls));
            check_value("color", 32'(o_pack.color), 32'(e_color));
            check_value("x", 32'(o_pack.x), e_x);
            check_value("y", 32'(o_pack.y), e_y);
            if (o_pack.de) begin
                de_count++;
            end
            if (o_pack.line_start) begin
                line_count++;
            end
        end
    end

    // Random pixels every cycle, optional random vsync pulses
    task automatic run_cycles(input int count, input bit pulses);
        logic [31:0] rnd;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #1;
            rnd    = $random(seed);
            i_data = rnd[15:0];
            i_href = rnd[16];
            if (pulses) begin
                i_vsync = (rnd[20:17] == 4'd0);
            end
        end
    endtask

    // Edges from driving vsync high until hs shows in the packet
    task automatic wait_first_hs(output int edges, output bit ok);
        edges = 0;
        while (!o_pack.hs && edges < LIMIT) begin
            run_cycles(1, 1'b0);
            edges++;
        end
        ok = o_pack.hs;
        if (!ok) begin
            $display("Timeout: hsync never appeared after the vsync rising edge");
            timeout_errors++;
        end
    endtask

    task automatic wait_for_de(output bit ok);
        int n;
        n = 0;
        while (!o_pack.de && n < LIMIT) begin
            run_cycles(1, 1'b1);
            n++;
        end
        ok = o_pack.de;
        if (!ok) begin
            $display("Timeout: data enable never went high");
            timeout_errors++;
        end
    endtask

    initial begin
        logic [31:0] rnd;
        int          edges;
        bit          ok;
        svg_rstn = 1'b0;
        i_vsync  = 1'b0;
        i_href   = 1'b0;
        i_data   = '0;

        run_cycles(3, 1'b0);
        svg_rstn = 1'b1;

        // Idle before the source frame starts
        rnd = $random(seed);
        run_cycles(5 + int'(rnd[3:0]), 1'b0);
        check_value("packet before vsync", 32'(o_pack == '0), 1);

        i_vsync = 1'b1;
        wait_first_hs(edges, ok);
        if (ok) begin
            i_vsync = 1'b0;
            check_value("edges from vsync to first hs", edges, 2);
            run_cycles(2 * FRAME + 20, 1'b1); // Extra pulses must not realign
            wait_for_de(ok);
        end

        // Reset in the middle of a frame
        if (ok) begin
            rnd = $random(seed);
            run_cycles(int'(rnd[2:0]), 1'b1);
            svg_rstn = 1'b0;
            i_vsync  = 1'b0;
            run_cycles(3, 1'b0);
            svg_rstn = 1'b1;
            check_value("packet after reset", 32'(o_pack == '0), 1);

            rnd = $random(seed);
            run_cycles(5 + int'(rnd[3:0]), 1'b0);
            check_value("packet before realign", 32'(o_pack == '0), 1);

            i_vsync = 1'b1;
            wait_first_hs(edges, ok);
        end

        if (ok) begin
            i_vsync = 1'b0;
            check_value("edges from vsync to first hs after reset", edges, 2);

            run_cycles(FRAME + 30, 1'b1);

            check_value("enough active pixels", 32'(de_count >= 3 * H_ACT * V_ACT), 1);
            check_value("enough active lines", 32'(line_count >= 3 * V_ACT), 1);
        end
        close_run();
    end

endmodule : hdmi_display_tb

// ==== compile.f ====
source/video_timing_pkg.sv
source/pixel_pkg.sv
source/display_ctrl.sv
source/sync_gen.sv
source/pixel_delay.sv
source/disp_pack.sv
source/hdmi_display.sv
bench/hdmi_display_sva.sv
bench/hdmi_display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f compile.f \
    --top-module hdmi_display_tb \
    -o hdmi_display_sim

out=$(./obj_dir/hdmi_display_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Everything OK"; then
    exit 0
fi
exit 1
